// ==== source/decFz_consts.svh ====
`ifndef DECFZ_CONSTS_SVH
`define DECFZ_CONSTS_SVH

// special register ids
`define GR_ZZR 6'h3F
`define GR_IMM 6'h3E
`define GR_DLR 6'h30
`define GR_PC 6'h31
`define GR_GBR 6'h32

// condition field value for always
`define IXC_AL 2'b00

// register fields
`define FLD_N 7:4
`define FLD_M 3:0
`define FLD_O 23:20

// extension bits
`define BIT_Q 27
`define BIT_N 26
`define BIT_M 25
`define BIT_I 24

// F-block marker, all ones for a valid F word
`define FLD_FX 15:13

// block and minor op fields
`define FLD_BLK 11:8
`define FLD_MINOR 31:28
`define FLD_SUBMINOR 19:16

`endif

// ==== source/decFzPkg.sv ====
package decFzPkg;

	typedef logic [31:0] istrWord_t;
	typedef logic [5:0] regId_t;
	typedef logic [32:0] immVal_t;

	// condition in the top 2 bits, major op below
	typedef logic [7:0] uCmd_t;
	typedef logic [7:0] uIxt_t;
	typedef logic [5:0] uCmdIx_t;

	typedef enum logic [5:0] {
		NMID_NOP = 6'h00,
		NMID_INVOP = 6'h01,
		NMID_MOV_MR = 6'h02,
		NMID_LEA_MR = 6'h03,
		NMID_ALU3 = 6'h04,
		NMID_MOV_IR = 6'h05
	} opNmid_e;

	typedef enum logic [3:0] {
		FORM_INV,
		FORM_REGREG,
		FORM_REGIMMREG,
		FORM_LDREGDISPREG,
		FORM_IMM12Z,
		FORM_IMM12N
	} opForm_e;

	typedef enum logic [2:0] {
		ITY_SB,
		ITY_UW,
		ITY_NW
	} opIty_e;

	// access size and signedness of a memory op
	typedef enum logic [2:0] {
		BTY_SB = 3'd0,
		BTY_SW = 3'd1,
		BTY_SL = 3'd2,
		BTY_SQ = 3'd3,
		BTY_UB = 3'd4,
		BTY_UW = 3'd5,
		BTY_UL = 3'd6,
		BTY_UQ = 3'd7
	} opBty_e;

	localparam uCmdIx_t UCIX_ADD = 6'h00;
	localparam uCmdIx_t UCIX_SUB = 6'h01;
	localparam uCmdIx_t UCIX_AND = 6'h05;
	localparam uCmdIx_t UCIX_OR = 6'h06;
	localparam uCmdIx_t UCIX_XOR = 6'h07;
	localparam uCmdIx_t UCIX_LDIX = 6'h00;

endpackage

// ==== source/decOpCtrl.sv ====
`timescale 1ns/1ps

`include "decFz_consts.svh"

module decOpCtrl import decFzPkg::*; (
	input logic clock,
	input logic rstN,
	input logic istrValid,
	input istrWord_t istrWord,
	input regId_t regN,
	input regId_t regM,
	input regId_t regO,
	input logic rmIsBase,
	input immVal_t imm,
	output istrWord_t stageWord,
	output opForm_e stageForm,
	output opIty_e stageIty,
	output logic idValid,
	output regId_t idRegN,
	output regId_t idRegM,
	output regId_t idRegO,
	output immVal_t idImm,
	output uCmd_t idUCmd,
	output uIxt_t idUIxt,
	output logic idInvalid
);

	logic exQ;
	logic aluHit;
	opForm_e nextForm;
	opIty_e nextIty;
	opBty_e nextBty;
	opNmid_e nextNmid;
	uCmdIx_t nextIx;

	logic stageValid;
	opBty_e stageBty;
	opNmid_e stageNmid;
	uCmdIx_t stageIx;

	uCmd_t packCmd;
	uIxt_t packIxt;

	assign exQ = istrWord[`BIT_Q];

	// stage 1 classification
	always_comb begin
		nextForm = FORM_INV;
		nextIty = ITY_SB;
		nextBty = BTY_SB;
		nextNmid = NMID_INVOP;
		nextIx = UCIX_ADD;
		aluHit = 1'b0;
		casez (istrWord[`FLD_BLK])
			4'b0z00: begin
				if (istrWord[`FLD_MINOR] == 4'h1) begin
					aluHit = 1'b1;
					case (istrWord[`FLD_SUBMINOR])
						4'h0: nextIx = UCIX_ADD;
						4'h1: nextIx = UCIX_SUB;
						4'h5: nextIx = UCIX_AND;
						4'h6: nextIx = UCIX_OR;
						4'h7: nextIx = UCIX_XOR;
						default: aluHit = 1'b0;
					endcase
				end
				if (aluHit) begin
					nextNmid = NMID_ALU3;
					nextForm = FORM_REGREG;
				end
			end
			4'b0z01: begin
				case (istrWord[`FLD_MINOR])
					4'h0, 4'h1, 4'h2, 4'h3: begin
						// Q clear here is a store
						if (exQ) begin
							nextNmid = NMID_LEA_MR;
							nextForm = FORM_LDREGDISPREG;
							nextBty = opBty_e'({1'b0, istrWord[29:28]});
						end
					end
					4'h8, 4'h9, 4'hA, 4'hB: begin
						nextNmid = NMID_MOV_MR;
						nextForm = FORM_LDREGDISPREG;
						case (istrWord[29:28])
							2'd0: nextBty = exQ ? BTY_UB : BTY_SB;
							2'd1: nextBty = exQ ? BTY_UW : BTY_SW;
							2'd2: nextBty = exQ ? BTY_UL : BTY_SL;
							default: nextBty = exQ ? BTY_SQ : BTY_SL;
						endcase
					end
					default: nextForm = FORM_INV;
				endcase
			end
			4'b0z10: begin
				aluHit = 1'b1;
				nextIty = ITY_UW;
				case (istrWord[`FLD_MINOR])
					4'h0: nextIx = UCIX_ADD;
					4'h1: begin
						nextIx = UCIX_ADD;
						nextIty = ITY_NW;
					end
					4'h5: nextIx = UCIX_AND;
					4'h6: nextIx = UCIX_OR;
					4'h7: nextIx = UCIX_XOR;
					default: aluHit = 1'b0;
				endcase
				if (aluHit) begin
					nextNmid = NMID_ALU3;
					nextForm = FORM_REGIMMREG;
				end
			end
			4'hA: begin
				nextNmid = NMID_MOV_IR;
				nextForm = FORM_IMM12Z;
				nextIx = UCIX_LDIX;
			end
			4'hB: begin
				nextNmid = NMID_MOV_IR;
				nextForm = FORM_IMM12N;
				nextIx = UCIX_LDIX;
			end
			default: nextForm = FORM_INV;
		endcase
		if (istrWord[`FLD_FX] != 3'b111) begin
			nextForm = FORM_INV;
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			stageValid <= 1'b0;
		end else begin
			stageValid <= istrValid;
		end
	end

	always_ff @(posedge clock) begin
		if (istrValid) begin
			stageWord <= istrWord;
			stageForm <= nextForm;
			stageIty <= nextIty;
			stageBty <= nextBty;
			stageNmid <= nextNmid;
			stageIx <= nextIx;
		end
	end

	// micro-command and micro-index packing
	always_comb begin
		packCmd = {`IXC_AL, stageNmid};
		packIxt = {`IXC_AL, stageIx};
		case (stageForm)
			FORM_LDREGDISPREG: begin
				if (rmIsBase) begin
					packIxt = {`IXC_AL, stageBty[1:0], 1'b1, stageBty[2], 2'b00};
				end else begin
					packIxt = {`IXC_AL, stageBty[1:0], 1'b1, stageBty};
				end
			end
			FORM_INV: begin
				packCmd = {`IXC_AL, NMID_INVOP};
				packIxt = '0;
			end
			default: packIxt = {`IXC_AL, stageIx};
		endcase
	end

	// stage 2, outputs hold between captures
	always_ff @(posedge clock) begin
		if (!rstN) begin
			idValid <= 1'b0;
			idRegN <= `GR_ZZR;
			idRegM <= `GR_ZZR;
			idRegO <= `GR_ZZR;
			idImm <= '0;
			idUCmd <= {`IXC_AL, NMID_NOP};
			idUIxt <= '0;
			idInvalid <= 1'b0;
		end else begin
			idValid <= stageValid;
			if (stageValid) begin
				idRegN <= regN;
				idRegM <= regM;
				idRegO <= regO;
				idImm <= imm;
				idUCmd <= packCmd;
				idUIxt <= packIxt;
				idInvalid <= (stageForm == FORM_INV);
			end
		end
	end

endmodule

// ==== source/decRegSelect.sv ====
`timescale 1ns/1ps

`include "decFz_consts.svh"

module decRegSelect import decFzPkg::*; (
	input istrWord_t stageWord,
	input opForm_e stageForm,
	input opIty_e stageIty,
	output regId_t regN,
	output regId_t regM,
	output regId_t regO,
	output logic rmIsBase
);

	regId_t dflN;
	regId_t dflM;
	regId_t dflO;

	// low ids and the all-ones id land in the special range unless extended
	function automatic regId_t regDefault(input logic [3:0] fld, input logic ext);
		logic special;
		special = (fld[3:1] == 3'b000) || (fld == 4'hF);
		return {special & !ext, ext, fld};
	endfunction

	assign dflN = regDefault(stageWord[`FLD_N], stageWord[`BIT_N]);
	assign dflM = regDefault(stageWord[`FLD_M], stageWord[`BIT_M]);
	assign dflO = regDefault(stageWord[`FLD_O], stageWord[`BIT_I]);

	always_comb begin
		regN = `GR_ZZR;
		regM = `GR_ZZR;
		regO = `GR_ZZR;
		rmIsBase = 1'b0;
		case (stageForm)
			FORM_REGREG: begin
				// only the SB operand order is decoded
				if (stageIty == ITY_SB) begin
					regN = dflN;
					regM = dflM;
					regO = dflO;
				end
			end
			FORM_REGIMMREG: begin
				regN = dflN;
				regM = dflM;
				regO = `GR_IMM;
			end
			FORM_LDREGDISPREG: begin
				regN = dflN;
				regM = dflM;
				regO = `GR_IMM;
				// R0 base means PC, R1 base means GBR
				if (dflM[4:1] == 4'b0000) begin
					regM = dflM[0] ? `GR_GBR : `GR_PC;
					rmIsBase = 1'b1;
				end
			end
			FORM_IMM12Z, FORM_IMM12N: begin
				regN = `GR_DLR;
				regM = `GR_DLR;
				regO = `GR_IMM;
			end
			default: begin
				regN = `GR_ZZR;
				regM = `GR_ZZR;
				regO = `GR_ZZR;
			end
		endcase
	end

endmodule

// ==== source/decImmExtend.sv ====
`timescale 1ns/1ps

module decImmExtend import decFzPkg::*; (
	input istrWord_t stageWord,
	input opForm_e stageForm,
	input opIty_e stageIty,
	output immVal_t imm
);

	logic [8:0] imm9;
	logic [23:0] imm24;

	assign imm9 = stageWord[24:16];

	// low byte of the word is the high part of the 24-bit load
	assign imm24 = {stageWord[7:0], stageWord[31:16]};

	always_comb begin
		imm = '0;
		case (stageForm)
			FORM_REGREG: begin
				imm = {28'h0, stageWord[4:0]};
			end
			FORM_LDREGDISPREG: begin
				imm = {24'h0, imm9};
			end
			FORM_REGIMMREG: begin
				if (stageIty == ITY_NW) begin
					imm = {{24{1'b1}}, imm9};
				end else begin
					imm = {24'h0, imm9};
				end
			end
			FORM_IMM12Z: begin
				imm = {9'h000, imm24};
			end
			FORM_IMM12N: begin
				imm = {9'h1FF, imm24};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

// ==== source/decOpFz.sv ====
`timescale 1ns/1ps

module decOpFz import decFzPkg::*; (
	input logic clock,
	input logic rstN,
	input logic istrValid,
	input istrWord_t istrWord,
	output logic idValid,
	output regId_t idRegN,
	output regId_t idRegM,
	output regId_t idRegO,
	output immVal_t idImm,
	output uCmd_t idUCmd,
	output uIxt_t idUIxt,
	output logic idInvalid
);

	istrWord_t stageWord;
	opForm_e stageForm;
	opIty_e stageIty;
	regId_t regN;
	regId_t regM;
	regId_t regO;
	logic rmIsBase;
	immVal_t imm;

	decOpCtrl ctrl_i (
		.clock(clock),
		.rstN(rstN),
		.istrValid(istrValid),
		.istrWord(istrWord),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.rmIsBase(rmIsBase),
		.imm(imm),
		.stageWord(stageWord),
		.stageForm(stageForm),
		.stageIty(stageIty),
		.idValid(idValid),
		.idRegN(idRegN),
		.idRegM(idRegM),
		.idRegO(idRegO),
		.idImm(idImm),
		.idUCmd(idUCmd),
		.idUIxt(idUIxt),
		.idInvalid(idInvalid)
	);

	// both decode helpers sit inside stage 2 with no added latency
	decRegSelect regSel_i (
		.stageWord(stageWord),
		.stageForm(stageForm),
		.stageIty(stageIty),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.rmIsBase(rmIsBase)
	);

	decImmExtend immExt_i (
		.stageWord(stageWord),
		.stageForm(stageForm),
		.stageIty(stageIty),
		.imm(imm)
	);

endmodule

// ==== bench/decOpFz_asserts.sv ====
`timescale 1ns/1ps

`include "decFz_consts.svh"

module decOpFzAsserts import decFzPkg::*; (
	input logic clock,
	input logic rstN,
	input logic istrValid,
	input logic idValid,
	input logic idInvalid,
	input regId_t idRegN,
	input regId_t idRegM,
	input regId_t idRegO
);

	validLowInReset: assert property (@(posedge clock) !rstN |=> !idValid)
		else $error("idValid high while in reset");

	// stage 1 then stage 2
	validLatency: assert property (@(posedge clock) disable iff (!rstN)
		idValid == $past(istrValid, 2))
		else $error("idValid does not follow istrValid by two cycles");

	invalidZzr: assert property (@(posedge clock) disable iff (!rstN)
		idInvalid |-> (idRegN == `GR_ZZR && idRegM == `GR_ZZR && idRegO == `GR_ZZR))
		else $error("invalid op with a register id other than ZZR");

endmodule

bind decOpCtrl decOpFzAsserts asserts_i (
	.clock(clock),
	.rstN(rstN),
	.istrValid(istrValid),
	.idValid(idValid),
	.idInvalid(idInvalid),
	.idRegN(idRegN),
	.idRegM(idRegM),
	.idRegO(idRegO)
);

// ==== bench/decOpFzModel.svh ====
`ifndef DECOPFZMODEL_SVH
`define DECOPFZMODEL_SVH

`include "decFz_consts.svh"

// expected decode result of one strobed word
typedef struct packed {
	regId_t regN;
	regId_t regM;
	regId_t regO;
	immVal_t imm;
	uCmd_t cmd;
	uIxt_t ixt;
	logic inv;
	logic [2:0] grp;
	logic [31:0] dueEdge;
} expRec_t;

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s ^ (s << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// R0, R1 and R15 map into the special range unless extended
function automatic regId_t expectReg(input logic [3:0] fld, input logic ext);
	logic low;
	low = (fld < 4'd2) || (fld == 4'hF);
	return {low && !ext, ext, fld};
endfunction

// kept ALU ops, their minor op code equals the nibble
function automatic logic aluKept(input logic [3:0] nib);
	return (nib == 4'h0) || (nib == 4'h1) || ((nib >= 4'h5) && (nib <= 4'h7));
endfunction

function automatic expRec_t resetRec();
	expRec_t e;
	e = '0;
	e.regN = `GR_ZZR;
	e.regM = `GR_ZZR;
	e.regO = `GR_ZZR;
	e.cmd = {`IXC_AL, NMID_NOP};
	return e;
endfunction

function automatic expRec_t modelDecode(input istrWord_t w);
	expRec_t e;
	logic [3:0] blk;
	logic [3:0] mn;
	logic [1:0] sz;
	logic [2:0] bty;
	blk = w[`FLD_BLK];
	mn = w[`FLD_MINOR];
	sz = mn[1:0];
	e = resetRec();
	e.cmd = {`IXC_AL, NMID_INVOP};
	e.inv = 1'b1;
	if (w[`FLD_FX] != 3'b111) begin
		return e;
	end
	if ((blk == 4'h0 || blk == 4'h4) && mn == 4'h1 && aluKept(w[`FLD_SUBMINOR])) begin
		e.regN = expectReg(w[`FLD_N], w[`BIT_N]);
		e.regM = expectReg(w[`FLD_M], w[`BIT_M]);
		e.regO = expectReg(w[`FLD_O], w[`BIT_I]);
		e.imm = {28'h0, w[4:0]};
		e.cmd = {`IXC_AL, NMID_ALU3};
		e.ixt = {`IXC_AL, 2'b00, w[`FLD_SUBMINOR]};
		e.inv = 1'b0;
	end else if ((blk == 4'h1 || blk == 4'h5) &&
			(mn[3:2] == 2'b10 || (mn[3:2] == 2'b00 && w[`BIT_Q]))) begin
		if (mn[3]) begin
			if (w[`BIT_Q])
				bty = (sz == 2'd3) ? 3'd3 : {1'b1, sz};
			else
				bty = (sz == 2'd3) ? 3'd2 : {1'b0, sz};
			e.cmd = {`IXC_AL, NMID_MOV_MR};
		end else begin
			bty = {1'b0, sz};
			e.cmd = {`IXC_AL, NMID_LEA_MR};
		end
		e.regN = expectReg(w[`FLD_N], w[`BIT_N]);
		e.regO = `GR_IMM;
		e.imm = {24'h0, w[24:16]};
		// base of R0 or R1 goes to PC or GBR
		if (!w[`BIT_M] && w[3:1] == 3'b000) begin
			e.regM = w[0] ? `GR_GBR : `GR_PC;
			e.ixt = {`IXC_AL, bty[1:0], 1'b1, bty[2], 2'b00};
		end else begin
			e.regM = expectReg(w[`FLD_M], w[`BIT_M]);
			e.ixt = {`IXC_AL, bty[1:0], 1'b1, bty};
		end
		e.inv = 1'b0;
	end else if ((blk == 4'h2 || blk == 4'h6) && aluKept(mn)) begin
		e.regN = expectReg(w[`FLD_N], w[`BIT_N]);
		e.regM = expectReg(w[`FLD_M], w[`BIT_M]);
		e.regO = `GR_IMM;
		// minor 1 is the ones-extended ADD
		e.imm = (mn == 4'h1) ? {{24{1'b1}}, w[24:16]} : {24'h0, w[24:16]};
		e.cmd = {`IXC_AL, NMID_ALU3};
		e.ixt = {`IXC_AL, 2'b00, (mn == 4'h1) ? 4'h0 : mn};
		e.inv = 1'b0;
	end else if (blk == 4'hA || blk == 4'hB) begin
		e.regN = `GR_DLR;
		e.regM = `GR_DLR;
		e.regO = `GR_IMM;
		e.imm = {(blk == 4'hB) ? 9'h1FF : 9'h000, w[7:0], w[31:16]};
		e.cmd = {`IXC_AL, NMID_MOV_IR};
		e.ixt = {`IXC_AL, UCIX_LDIX};
		e.inv = 1'b0;
	end
	return e;
endfunction

`endif

// ==== bench/decOpFzTb.sv ====
`timescale 1ns/1ps

`include "decFz_consts.svh"

module decOpFzTb import decFzPkg::*; ();

	localparam int NUM_WORDS = 400;

	logic clock;
	logic rstN;
	logic istrValid;
	istrWord_t istrWord;
	logic idValid;
	regId_t idRegN;
	regId_t idRegM;
	regId_t idRegO;
	immVal_t idImm;
	uCmd_t idUCmd;
	uIxt_t idUIxt;
	logic idInvalid;

	`include "decOpFzModel.svh"

	logic [31:0] rngState;
	logic [31:0] edgeCount;
	logic monitorOn;
	logic runDone;
	expRec_t expQ[$];
	expRec_t lastRec;

	decOpFz dut_i (
		.clock(clock),
		.rstN(rstN),
		.istrValid(istrValid),
		.istrWord(istrWord),
		.idValid(idValid),
		.idRegN(idRegN),
		.idRegM(idRegM),
		.idRegO(idRegO),
		.idImm(idImm),
		.idUCmd(idUCmd),
		.idUIxt(idUIxt),
		.idInvalid(idInvalid)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	always @(posedge clock) edgeCount <= edgeCount + 32'd1;

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	function automatic string groupName(input logic [2:0] g);
		case (g)
			3'd0: return "f0 alu";
			3'd1: return "f1 mem";
			3'd2: return "f2 imm";
			3'd3: return "fa/fb dlr";
			default: return "invalid op";
		endcase
	endfunction

	function automatic logic [3:0] pickAlu(input logic [2:0] sel);
		case (sel)
			3'd0, 3'd5: return 4'h0;
			3'd1, 3'd6: return 4'h1;
			3'd2: return 4'h5;
			3'd3: return 4'h6;
			default: return 4'h7;
		endcase
	endfunction

	// random fields with the group's fixed bits on top
	function automatic istrWord_t makeWord(input logic [2:0] grp, input logic [31:0] r,
			input logic [31:0] s);
		istrWord_t w;
		w = r;
		w[`FLD_FX] = 3'b111;
		case (grp)
			3'd0: begin
				w[`FLD_BLK] = {1'b0, s[0], 2'b00};
				w[`FLD_MINOR] = 4'h1;
				w[`FLD_SUBMINOR] = pickAlu(s[6:4]);
			end
			3'd1: begin
				w[`FLD_BLK] = {1'b0, s[0], 2'b01};
				if (s[1]) begin
					w[`FLD_MINOR] = {2'b00, s[3:2]};
					w[`BIT_Q] = 1'b1;
				end else begin
					w[`FLD_MINOR] = {2'b10, s[3:2]};
				end
				// R0 or R1 base often enough
				if (s[5:4] == 2'b00) begin
					w[`BIT_M] = 1'b0;
					w[`FLD_M] = {3'b000, s[6]};
				end
			end
			3'd2: begin
				w[`FLD_BLK] = {1'b0, s[0], 2'b10};
				w[`FLD_MINOR] = pickAlu(s[6:4]);
			end
			3'd3: w[`FLD_BLK] = {3'b101, s[0]};
			default: begin
				case (s[2:1])
					2'd0: w[`FLD_FX] = {s[3], 2'b10};
					2'd1: begin
						// store form
						w[`FLD_BLK] = {1'b0, s[0], 2'b01};
						w[`FLD_MINOR] = {2'b00, s[4:3]};
						w[`BIT_Q] = 1'b0;
					end
					2'd2: begin
						w[`FLD_BLK] = {1'b0, s[0], 2'b00};
						w[`FLD_MINOR] = 4'h1;
						w[`FLD_SUBMINOR] = {1'b1, s[5:3]};
					end
					default: begin
						w[`FLD_BLK] = {1'b0, s[0], 2'b10};
						w[`FLD_MINOR] = {1'b1, s[5:3]};
					end
				endcase
			end
		endcase
		return w;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		runDone = 1'b1;
		$display("Some tests failed");
		$fatal(1, "decoder check failed");
	endtask

	task automatic checkReg(input string name, input regId_t exp, input regId_t act);
		if (act !== exp)
			failRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkImm(input string name, input immVal_t exp, input immVal_t act);
		if (act !== exp)
			failRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkCmd(input string name, input uCmd_t exp, input uCmd_t act);
		if (act !== exp)
			failRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkIxt(input string name, input uIxt_t exp, input uIxt_t act);
		if (act !== exp)
			failRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (act !== exp)
			failRun($sformatf("mismatch %s expected %b actual %b", name, exp, act));
	endtask

	task automatic compareOutputs(input string tag, input expRec_t e);
		checkReg({tag, " regN"}, e.regN, idRegN);
		checkReg({tag, " regM"}, e.regM, idRegM);
		checkReg({tag, " regO"}, e.regO, idRegO);
		checkImm({tag, " imm"}, e.imm, idImm);
		checkCmd({tag, " uCmd"}, e.cmd, idUCmd);
		checkIxt({tag, " uIxt"}, e.ixt, idUIxt);
		checkFlag({tag, " invalid"}, e.inv, idInvalid);
	endtask

	// scoreboard samples at the falling edge where outputs are stable
	always @(negedge clock) begin
		expRec_t e;
		if (monitorOn) begin
			if (idValid) begin
				if (expQ.size() == 0) begin
					failRun("idValid pulse without a strobed word in flight");
				end else begin
					e = expQ.pop_front();
					if (edgeCount != e.dueEdge)
						failRun($sformatf("mismatch %s latency expected edge %0d actual edge %0d",
							groupName(e.grp), e.dueEdge, edgeCount));
					compareOutputs(groupName(e.grp), e);
					lastRec = e;
				end
			end else begin
				compareOutputs("hold", lastRec);
			end
		end
	end

	initial begin
		repeat (NUM_WORDS * 4 + 100) @(posedge clock);
		failRun("watchdog expired, the decode pipeline stalled");
	end

	initial begin
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] g;
		logic [2:0] grp;
		logic [1:0] gap;
		istrWord_t w;
		expRec_t e;
		rngState = 32'd73;
		edgeCount = '0;
		monitorOn = 1'b0;
		runDone = 1'b0;
		rstN = 1'b0;
		istrValid = 1'b0;
		istrWord = '0;
		lastRec = resetRec();
		repeat (5) @(posedge clock);
		#1;
		rstN = 1'b1;
		@(negedge clock);
		#1;
		checkFlag("reset idValid", 1'b0, idValid);
		compareOutputs("reset", lastRec);
		monitorOn = 1'b1;
		for (int i = 0; i < NUM_WORDS; i++) begin
			r = nextRand();
			s = nextRand();
			g = nextRand();
			grp = s[10:8] % 3'd5;
			gap = (g[1:0] == 2'd3) ? 2'd0 : g[1:0];
			repeat (gap) begin
				@(posedge clock);
				#1;
				istrValid = 1'b0;
				istrWord = nextRand();
			end
			@(posedge clock);
			#1;
			w = makeWord(grp, r, s);
			e = modelDecode(w);
			e.grp = grp;
			e.dueEdge = edgeCount + 32'd2;
			expQ.push_back(e);
			istrValid = 1'b1;
			istrWord = w;
		end
		@(posedge clock);
		#1;
		istrValid = 1'b0;
		// last word leaves stage 2 two edges after its strobe
		repeat (4) @(negedge clock);
		if (expQ.size() == 0) begin
			runDone = 1'b1;
			$display("All tests passed");
			$finish;
		end else begin
			failRun("strobed words left without an idValid pulse");
		end
	end

	final begin
		if (!runDone) begin
			$display("Some tests failed");
		end
	end

endmodule

// ==== decOpFz.f ====
+incdir+source
+incdir+bench
source/decFzPkg.sv
source/decOpCtrl.sv
source/decRegSelect.sv
source/decImmExtend.sv
source/decOpFz.sv
bench/decOpFz_asserts.sv
bench/decOpFzTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module decOpFzTb -f decOpFz.f

out=$(./obj_dir/VdecOpFzTb 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "All tests passed"
